// ==== hw/fdc_pkg.sv ====
package fdc_pkg;

	// ====================
	// host register map
	localparam logic [1:0] REG_CMD_STATUS = 2'd0;
	localparam logic [1:0] REG_TRACK      = 2'd1;
	localparam logic [1:0] REG_SECTOR     = 2'd2;
	localparam logic [1:0] REG_DATA       = 2'd3;

	// ====================
	// timing, in clk_sys cycles
	localparam int SETTLE_CYCLES     = 64;   // type I busy time
	localparam int LOST_DATA_CYCLES  = 256;  // drq watchdog
	localparam int SECTOR_GAP_CYCLES = 16;   // pause before each drq
	localparam int TIMER_W           = $clog2(LOST_DATA_CYCLES + 1);

	typedef logic [TIMER_W-1:0] timer_t;

	// ====================
	// geometry, indexed by size_code
	localparam logic [7:0] SPT_TABLE       [5] = '{8'd26, 8'd16, 8'd9, 8'd5, 8'd10};
	localparam logic [1:0] SIZE_CODE_TABLE [5] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd2};  // 128 << n

	typedef enum logic [3:0] {
		CMD_RESTORE, CMD_SEEK, CMD_STEP, CMD_STEP_IN, CMD_STEP_OUT,
		CMD_READ, CMD_WRITE, CMD_FORCE_INT, CMD_NONE
	} fdc_cmd_e;

	typedef enum logic [3:0] {
		idle, settle, locate, fetch, wait_host, collect, store, abort, end_cmd
	} fdc_state_e;

	typedef struct packed {
		logic       valid;
		fdc_cmd_e   op;
		logic [4:0] flags;  // bit 4 update/multi, bit 3 head load
	} host_cmd_t;

	typedef struct packed {
		logic status_read;
		logic data_read;
		logic data_write;
	} host_evt_t;

	typedef struct packed {
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] data;
	} fdc_regs_t;

	typedef struct packed {
		logic       track_we;
		logic [7:0] track;
		logic       sector_we;
		logic [7:0] sector;
		logic       data_we;
		logic [7:0] data;
	} reg_upd_t;

	typedef struct packed {
		logic        sector_valid;
		logic [10:0] sector_len;
		logic [19:0] base_addr;   // first byte of the sector in the image
	} geom_t;

	typedef struct packed {
		logic        valid;
		logic        we;
		logic [19:0] addr;
		logic [7:0]  wdata;
	} img_req_t;

	typedef struct packed {
		logic       done;
		logic [7:0] rdata;
	} img_rsp_t;

endpackage

// ==== hw/fdc_geometry.sv ====
module fdc_geometry (
	input  logic [2:0]         size_code,
	input  logic               side,
	input  logic [7:0]         head_track,
	input  fdc_pkg::fdc_regs_t regs,
	output fdc_pkg::geom_t     geom
);

	logic [7:0]  spt;       // sectors per track
	logic [1:0]  len_code;  // sector length 128 << len_code
	logic [16:0] blk;       // linear sector number in the image
	logic [27:0] offset;

	// ====================
	// table lookup
	always_comb begin
		if (size_code <= 3'd4) begin
			spt      = fdc_pkg::SPT_TABLE[size_code];
			len_code = fdc_pkg::SIZE_CODE_TABLE[size_code];
		end else begin
			// unknown format, no sector ever matches
			spt      = 8'd0;
			len_code = 2'd0;
		end
	end

	// ====================
	// track-side-sector layout
	always_comb begin
		blk    = 17'({head_track, side}) * 17'(spt) + 17'(regs.sector) - 17'd1;
		offset = 28'(blk) << ({2'b00, len_code} + 4'd7);
	end

	always_comb begin
		geom.sector_valid = (regs.sector != 8'd0) && (regs.sector <= spt);
		geom.sector_len   = 11'd128 << len_code;
		geom.base_addr    = offset[19:0];  // image is 1 MB at most
	end

endmodule

// ==== hw/fdc_host_regs.sv ====
module fdc_host_regs (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [1:0]         wb_adr,
	input  logic [7:0]         wb_dat_w,
	output logic [7:0]         wb_dat_r,
	output logic               wb_ack,
	input  logic [7:0]         status,
	input  logic               busy,
	input  fdc_pkg::reg_upd_t  upd,
	output fdc_pkg::fdc_regs_t regs,
	output fdc_pkg::host_cmd_t cmd,
	output fdc_pkg::host_evt_t evt
);

	logic wr_cyc;  // write in its ack cycle
	logic rd_cyc;

	// ====================
	// bus handshake, ack one cycle after cyc/stb
	always_ff @(posedge clk_sys) begin
		if (rst)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;
	end

	assign wr_cyc = wb_ack & wb_we;
	assign rd_cyc = wb_ack & ~wb_we;

	always_comb begin
		case (wb_adr)
			fdc_pkg::REG_CMD_STATUS: wb_dat_r = status;
			fdc_pkg::REG_TRACK:      wb_dat_r = regs.track;
			fdc_pkg::REG_SECTOR:     wb_dat_r = regs.sector;
			default:                 wb_dat_r = regs.data;
		endcase
	end

	// ====================
	// register file, sequencer wins over host
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			regs <= '0;
		end else begin
			if (upd.track_we)
				regs.track <= upd.track;
			else if (wr_cyc && wb_adr == fdc_pkg::REG_TRACK && !busy)
				regs.track <= wb_dat_w;

			if (upd.sector_we)
				regs.sector <= upd.sector;
			else if (wr_cyc && wb_adr == fdc_pkg::REG_SECTOR && !busy)
				regs.sector <= wb_dat_w;

			if (upd.data_we)
				regs.data <= upd.data;
			else if (wr_cyc && wb_adr == fdc_pkg::REG_DATA)
				regs.data <= wb_dat_w;  // allowed while busy, feeds write sector
		end
	end

	// ====================
	// command decode, upper nibble
	always_comb begin
		cmd.valid = wr_cyc && wb_adr == fdc_pkg::REG_CMD_STATUS;
		cmd.flags = wb_dat_w[4:0];
		case (wb_dat_w[7:4])
			4'h0:       cmd.op = fdc_pkg::CMD_RESTORE;
			4'h1:       cmd.op = fdc_pkg::CMD_SEEK;
			4'h2, 4'h3: cmd.op = fdc_pkg::CMD_STEP;
			4'h4, 4'h5: cmd.op = fdc_pkg::CMD_STEP_IN;
			4'h6, 4'h7: cmd.op = fdc_pkg::CMD_STEP_OUT;
			4'h8, 4'h9: cmd.op = fdc_pkg::CMD_READ;
			4'ha, 4'hb: cmd.op = fdc_pkg::CMD_WRITE;
			4'hd:       cmd.op = fdc_pkg::CMD_FORCE_INT;
			default:    cmd.op = fdc_pkg::CMD_NONE;  // read address / track, format
		endcase
	end

	always_comb begin
		evt.status_read = rd_cyc && wb_adr == fdc_pkg::REG_CMD_STATUS;
		evt.data_read   = rd_cyc && wb_adr == fdc_pkg::REG_DATA;
		evt.data_write  = wr_cyc && wb_adr == fdc_pkg::REG_DATA;
	end

endmodule

// ==== hw/fdc_cmd_seq.sv ====
module fdc_cmd_seq (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               ready,
	input  logic               wp,
	input  fdc_pkg::host_cmd_t cmd,
	input  fdc_pkg::host_evt_t evt,
	input  fdc_pkg::fdc_regs_t regs,
	input  fdc_pkg::geom_t     geom,
	output fdc_pkg::reg_upd_t  upd,
	output logic [7:0]         head_track,
	output logic [7:0]         status,
	output logic               busy,
	output logic               drq,
	output logic               intrq,
	output fdc_pkg::img_req_t  img_req,
	input  fdc_pkg::img_rsp_t  img_rsp
);

	fdc_pkg::fdc_state_e state;
	fdc_pkg::timer_t     timer;     // settle, gap and watchdog
	logic [10:0]         byte_cnt;
	logic                cmd_mode;  // 0 type I, 1 type II
	logic                dir_in;    // last step direction, in = +1
	logic                multi;
	logic                is_write;
	logic                head_loaded;
	logic                rnf;       // record not found / seek error
	logic                wr_fault;
	logic                lost_data;
	logic                img_wait;  // image access still in flight
	logic                serviced;
	logic                host_done;
	logic                byte_done;
	logic                last_byte;
	logic                step_in;
	logic [7:0]          new_track;

	always_comb begin
		if (!cmd_mode)
			status = {~ready, wp, head_loaded, rnf | ~ready,
				1'b0, head_track == 8'd0, 1'b0, busy};
		else
			status = {~ready, wp, wr_fault, rnf | ~ready,
				1'b0, lost_data, drq, busy};
	end

	always_comb begin
		img_req.valid = (state == fdc_pkg::fetch) || (state == fdc_pkg::store);
		img_req.we    = state == fdc_pkg::store;
		img_req.addr  = geom.base_addr + 20'(byte_cnt);
		img_req.wdata = regs.data;  // host byte, or the old one after lost data
	end

	assign serviced  = is_write ? evt.data_write : evt.data_read;
	assign host_done = drq && (serviced || timer == '0);
	assign byte_done = (state == fdc_pkg::wait_host && host_done) ||
		(state == fdc_pkg::store && img_rsp.done);
	assign last_byte = byte_cnt == geom.sector_len - 11'd1;

	// target track of a type I command
	always_comb begin
		case (cmd.op)
			fdc_pkg::CMD_STEP_IN:  step_in = 1'b1;
			fdc_pkg::CMD_STEP_OUT: step_in = 1'b0;
			default:               step_in = dir_in;
		endcase
		if (cmd.op == fdc_pkg::CMD_RESTORE)
			new_track = 8'd0;
		else if (cmd.op == fdc_pkg::CMD_SEEK)
			new_track = regs.data;
		else if (step_in)
			new_track = head_track + 8'd1;
		else if (head_track != 8'd0)
			new_track = head_track - 8'd1;
		else
			new_track = 8'd0;  // track 0 stop
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			img_wait <= 1'b0;
		else if (img_rsp.done)
			img_wait <= 1'b0;
		else if (img_req.valid)
			img_wait <= 1'b1;
	end

	// ====================
	// main sequencer
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state       <= fdc_pkg::idle;
			timer       <= '0;
			byte_cnt    <= '0;
			cmd_mode    <= 1'b0;
			dir_in      <= 1'b1;
			multi       <= 1'b0;
			is_write    <= 1'b0;
			head_loaded <= 1'b0;
			{rnf, wr_fault, lost_data} <= '0;
			head_track  <= 8'd0;
			{busy, drq, intrq} <= '0;
			upd         <= '0;
		end else begin
			upd <= '0;
			if (evt.status_read)
				intrq <= 1'b0;

			case (state)
				fdc_pkg::settle: begin
					if (timer == '0)
						state <= fdc_pkg::end_cmd;
					else
						timer <= timer - 1'b1;
				end
				fdc_pkg::locate: begin
					if (timer != '0) begin
						timer <= timer - 1'b1;  // let a sector update land
					end else if (!ready || !geom.sector_valid) begin
						rnf   <= 1'b1;
						state <= fdc_pkg::end_cmd;
					end else begin
						byte_cnt <= '0;
						timer    <= fdc_pkg::timer_t'(fdc_pkg::SECTOR_GAP_CYCLES - 1);
						state    <= is_write ? fdc_pkg::collect : fdc_pkg::fetch;
					end
				end
				fdc_pkg::fetch: begin
					if (img_rsp.done) begin
						upd.data_we <= 1'b1;
						upd.data    <= img_rsp.rdata;
						timer       <= fdc_pkg::timer_t'(fdc_pkg::SECTOR_GAP_CYCLES - 1);
						state       <= fdc_pkg::wait_host;
					end
				end
				fdc_pkg::wait_host, fdc_pkg::collect: begin
					if (!drq) begin
						if (timer == '0) begin
							drq   <= 1'b1;
							timer <= fdc_pkg::timer_t'(fdc_pkg::LOST_DATA_CYCLES - 1);
						end else begin
							timer <= timer - 1'b1;
						end
					end else if (host_done) begin
						drq <= 1'b0;
						if (!serviced)
							lost_data <= 1'b1;  // watchdog expired
						if (state == fdc_pkg::collect)
							state <= fdc_pkg::store;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				fdc_pkg::abort: begin
					{rnf, wr_fault, lost_data, drq} <= '0;
					if (!img_wait)
						state <= fdc_pkg::end_cmd;
				end
				fdc_pkg::end_cmd: begin
					{busy, drq} <= '0;
					intrq <= 1'b1;
					state <= fdc_pkg::idle;
				end
				default: ;
			endcase

			// next byte, next sector or done
			if (byte_done) begin
				if (!last_byte) begin
					byte_cnt <= byte_cnt + 11'd1;
					timer    <= fdc_pkg::timer_t'(fdc_pkg::SECTOR_GAP_CYCLES - 1);
					state    <= is_write ? fdc_pkg::collect : fdc_pkg::fetch;
				end else if (multi) begin
					upd.sector_we <= 1'b1;
					upd.sector    <= regs.sector + 8'd1;
					timer         <= fdc_pkg::timer_t'(1);
					state         <= fdc_pkg::locate;
				end else begin
					state <= fdc_pkg::end_cmd;
				end
			end

			// ====================
			// command accept
			if (cmd.valid && (state == fdc_pkg::idle || cmd.op == fdc_pkg::CMD_FORCE_INT)) begin
				case (cmd.op)
					fdc_pkg::CMD_RESTORE, fdc_pkg::CMD_SEEK, fdc_pkg::CMD_STEP,
					fdc_pkg::CMD_STEP_IN, fdc_pkg::CMD_STEP_OUT: begin
						cmd_mode      <= 1'b0;
						head_loaded   <= cmd.flags[3];
						dir_in        <= step_in;
						head_track    <= new_track;
						upd.track_we  <= (cmd.op == fdc_pkg::CMD_RESTORE) | cmd.flags[4];
						upd.track     <= new_track;
						{busy, intrq} <= 2'b10;
						timer         <= fdc_pkg::timer_t'(fdc_pkg::SETTLE_CYCLES - 2);
						state         <= fdc_pkg::settle;
					end
					fdc_pkg::CMD_READ, fdc_pkg::CMD_WRITE: begin
						cmd_mode <= 1'b1;
						{busy, drq, intrq} <= 3'b100;
						{rnf, wr_fault, lost_data} <= '0;
						multi    <= cmd.flags[4];
						is_write <= cmd.op == fdc_pkg::CMD_WRITE;
						timer    <= '0;
						if (cmd.op == fdc_pkg::CMD_WRITE && wp) begin
							wr_fault <= 1'b1;  // protected, image untouched
							state    <= fdc_pkg::end_cmd;
						end else begin
							state <= fdc_pkg::locate;
						end
					end
					fdc_pkg::CMD_FORCE_INT: begin
						cmd_mode <= 1'b0;
						intrq    <= 1'b0;
						if (state != fdc_pkg::idle)
							state <= fdc_pkg::abort;
						else
							{rnf, wr_fault, lost_data, drq, busy} <= '0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/fdc_img_master.sv ====
module fdc_img_master (
	input  logic              clk_sys,
	input  logic              rst,
	input  fdc_pkg::img_req_t req,
	output fdc_pkg::img_rsp_t rsp,
	output logic              img_cyc,
	output logic              img_stb,
	output logic              img_we,
	output logic [19:0]       img_adr,
	output logic [7:0]        img_dat_w,
	input  logic [7:0]        img_dat_r,
	input  logic              img_ack
);

	typedef enum logic {m_idle, m_active} mst_state_e;

	mst_state_e state;
	logic       done_q;
	logic [7:0] rdata_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state  <= m_idle;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				m_idle:   if (req.valid && !done_q) state <= m_active;  // not the finished one
				m_active: if (img_ack) begin
					done_q <= 1'b1;
					state  <= m_idle;
				end
				default: state <= m_idle;
			endcase
		end
	end

	// request payload and returned byte
	always_ff @(posedge clk_sys) begin
		if (state == m_idle && req.valid) begin
			img_we    <= req.we;
			img_adr   <= req.addr;
			img_dat_w <= req.wdata;
		end
		if (state == m_active && img_ack)
			rdata_q <= img_dat_r;
	end

	assign img_cyc = state == m_active;
	assign img_stb = img_cyc;

	always_comb begin
		rsp.done  = done_q;
		rsp.rdata = rdata_q;
	end

endmodule

// ==== hw/fdc_top.sv ====
module fdc_top (
	input  logic        clk_sys,
	input  logic        rst,
	// host side
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [7:0]  wb_dat_w,
	output logic [7:0]  wb_dat_r,
	output logic        wb_ack,
	output logic        drq,
	output logic        intrq,
	// drive
	input  logic        ready,
	input  logic        wp,
	input  logic        side,
	input  logic [2:0]  size_code,
	// disk image
	output logic        img_cyc,
	output logic        img_stb,
	output logic        img_we,
	output logic [19:0] img_adr,
	output logic [7:0]  img_dat_w,
	input  logic [7:0]  img_dat_r,
	input  logic        img_ack
);

	fdc_pkg::host_cmd_t cmd;
	fdc_pkg::host_evt_t evt;
	fdc_pkg::fdc_regs_t regs;
	fdc_pkg::reg_upd_t  upd;
	fdc_pkg::geom_t     geom;
	fdc_pkg::img_req_t  img_req;
	fdc_pkg::img_rsp_t  img_rsp;
	logic [7:0]         status;
	logic [7:0]         head_track;
	logic               busy;

	fdc_host_regs host_regs_i (
		.clk_sys(clk_sys), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.status(status), .busy(busy), .upd(upd), .regs(regs), .cmd(cmd), .evt(evt)
	);

	fdc_geometry geometry_i (
		.size_code(size_code), .side(side), .head_track(head_track),
		.regs(regs), .geom(geom)
	);

	fdc_cmd_seq cmd_seq_i (
		.clk_sys(clk_sys), .rst(rst), .ready(ready), .wp(wp),
		.cmd(cmd), .evt(evt), .regs(regs), .geom(geom), .upd(upd),
		.head_track(head_track), .status(status), .busy(busy), .drq(drq), .intrq(intrq),
		.img_req(img_req), .img_rsp(img_rsp)
	);

	fdc_img_master img_master_i (
		.clk_sys(clk_sys), .rst(rst), .req(img_req), .rsp(img_rsp),
		.img_cyc(img_cyc), .img_stb(img_stb), .img_we(img_we), .img_adr(img_adr),
		.img_dat_w(img_dat_w), .img_dat_r(img_dat_r), .img_ack(img_ack)
	);

endmodule

// ==== tests/fdc_image_mem.sv ====
module fdc_image_mem (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [19:0] adr,
	input  logic [7:0]  dat_w,
	output logic [7:0]  dat_r,
	output logic        ack
);

	logic [7:0] mem [logic [19:0]];  // written bytes only
	logic       pending;
	logic [1:0] wait_cnt;

	// unwritten bytes follow the whole address
	function automatic logic [7:0] fill_byte(input logic [19:0] a);
		return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
	endfunction

	initial begin
		ack   = 1'b0;
		dat_r = 8'h00;
	end

	always @(posedge clk_sys) begin
		if (rst) begin
			ack      <= 1'b0;
			pending  <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (!pending) begin
					pending  <= 1'b1;
					wait_cnt <= 2'($urandom_range(3, 0));  // wait states
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					pending <= 1'b0;
					ack     <= 1'b1;
					if (we)
						mem[adr] = dat_w;
					dat_r <= mem.exists(adr) ? mem[adr] : fill_byte(adr);
				end
			end
		end
	end

endmodule

// ==== tests/fdc_tb.sv ====
module fdc_tb;

	localparam int N_TYPE1     = 40;
	localparam int N_RW        = 12;
	localparam int N_FORCE     = 4;
	localparam int N_LOST      = 2;
	localparam int N_CMDS      = N_TYPE1 + 6 * N_RW + 2 * N_FORCE + 2 * N_LOST;
	localparam int MAX_SECTOR  = 1024;
	localparam int CYCLE_LIMIT = N_CMDS * (MAX_SECTOR * (fdc_pkg::LOST_DATA_CYCLES +
		fdc_pkg::SECTOR_GAP_CYCLES) + fdc_pkg::SETTLE_CYCLES) * 2;

	logic        clk_sys;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [7:0]  wb_dat_w;
	logic [7:0]  wb_dat_r;
	logic        wb_ack;
	logic        drq;
	logic        intrq;
	logic        ready;
	logic        wp;
	logic        side;
	logic [2:0]  size_code;
	logic        img_cyc;
	logic        img_stb;
	logic        img_we;
	logic [19:0] img_adr;
	logic [7:0]  img_dat_w;
	logic [7:0]  img_dat_r;
	logic        img_ack;

	// ====================
	// reference model state
	logic [7:0] m_head;
	logic [7:0] m_track;
	logic [7:0] m_sector;
	logic       m_dir_in;
	logic       m_loaded;
	logic       m_mode2;   // status in type II form
	logic       m_rnf;
	logic       m_wf;
	logic       m_lost;
	logic [7:0] img_model [logic [19:0]];
	int         cycles;

	fdc_top fdc_top_i (
		.clk_sys(clk_sys), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.drq(drq), .intrq(intrq), .ready(ready), .wp(wp), .side(side),
		.size_code(size_code),
		.img_cyc(img_cyc), .img_stb(img_stb), .img_we(img_we), .img_adr(img_adr),
		.img_dat_w(img_dat_w), .img_dat_r(img_dat_r), .img_ack(img_ack)
	);

	fdc_image_mem image_mem_i (
		.clk_sys(clk_sys), .rst(rst), .cyc(img_cyc), .stb(img_stb), .we(img_we),
		.adr(img_adr), .dat_w(img_dat_w), .dat_r(img_dat_r), .ack(img_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic int spt_of(input logic [2:0] sc);
		case (sc)
			3'd0:    return 26;
			3'd1:    return 16;
			3'd2:    return 9;
			3'd3:    return 5;
			default: return 10;
		endcase
	endfunction

	function automatic int len_of(input logic [2:0] sc);
		case (sc)
			3'd0:    return 128;
			3'd1:    return 256;
			3'd3:    return 1024;
			default: return 512;
		endcase
	endfunction

	// track-side-sector order
	function automatic logic [19:0] sector_addr(input logic [7:0] sec);
		int blk;
		blk = (int'(m_head) * 2 + int'(side)) * spt_of(size_code) + int'(sec) - 1;
		return 20'(blk * len_of(size_code));
	endfunction

	function automatic logic [7:0] image_byte(input logic [19:0] a);
		if (img_model.exists(a))
			return img_model[a];
		return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
	endfunction

	function automatic logic [7:0] exp_status();
		if (!m_mode2)
			return {~ready, wp, m_loaded, m_rnf | ~ready, 1'b0, m_head == 8'd0, 2'b00};
		return {~ready, wp, m_wf, m_rnf | ~ready, 1'b0, m_lost, 2'b00};
	endfunction

	// ====================
	// checks
	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error: status is %h, expected %h", got, exp);
			abort_run();
		end
	endtask

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("timeout, the DUT did not finish within %0d cycles", CYCLE_LIMIT);
				abort_run();
			end
		end
	end

	// ====================
	// host bus
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] dat,
			output logic [7:0] rdata);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do
			next_cycle();
		while (!wb_ack);
		rdata = wb_dat_r;
		next_cycle();  // ack cycle ends here
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
		wb_access(1'b0, adr, 8'h00, dat);
	endtask

	task automatic set_sector(input logic [7:0] s);
		wb_write(fdc_pkg::REG_SECTOR, s);
		m_sector = s;
	endtask

	task automatic type1_cmd(input logic [7:0] c, input logic [7:0] seek_to);
		logic [7:0] d;
		if (c[7:4] == 4'h1)
			wb_write(fdc_pkg::REG_DATA, seek_to);
		case (c[7:4])
			4'h0: m_head = 8'd0;
			4'h1: m_head = seek_to;
			default: begin
				if (c[7:4] >= 4'h4)
					m_dir_in = c[7:4] < 4'h6;
				if (m_dir_in)
					m_head = m_head + 8'd1;
				else if (m_head != 8'd0)
					m_head = m_head - 8'd1;
			end
		endcase
		if (c[7:4] == 4'h0 || c[4])
			m_track = m_head;
		m_loaded = c[3];
		m_mode2  = 1'b0;
		wb_write(fdc_pkg::REG_CMD_STATUS, c);
		while (!intrq)
			next_cycle();
		wb_read(fdc_pkg::REG_CMD_STATUS, d);
		check_status(d, exp_status());
		wb_read(fdc_pkg::REG_TRACK, d);
		check_byte("track register", d, m_track);
	endtask

	// read or write sector; skip_idx leaves one drq to the watchdog,
	// stop_idx sends force interrupt at that drq
	task automatic sector_cmd(input logic [7:0] c, input int skip_idx, input int stop_idx);
		logic [7:0] d;
		logic [7:0] cur_sec;
		logic [19:0] a;
		int         len;
		int         spt;
		int         idx;
		int         count;
		int         due;
		len     = len_of(size_code);
		spt     = spt_of(size_code);
		cur_sec = m_sector;
		idx     = 0;
		count   = 0;
		{m_mode2, m_rnf, m_wf, m_lost} = 4'b1000;
		if (c[5] && wp) begin
			due  = 0;
			m_wf = 1'b1;
		end else if (!ready || m_sector == 8'd0 || m_sector > spt) begin
			due   = 0;
			m_rnf = 1'b1;
		end else if (c[4]) begin
			due      = (spt - int'(m_sector) + 1) * len;
			m_rnf    = 1'b1;  // runs off the end of the track
			m_sector = 8'(spt + 1);
		end else begin
			due = len;
		end
		if (stop_idx >= 0)
			due = stop_idx;
		wb_write(fdc_pkg::REG_CMD_STATUS, c);
		forever begin
			while (!drq && !intrq)
				next_cycle();
			if (intrq)
				break;
			if (count == stop_idx) begin
				wb_write(fdc_pkg::REG_CMD_STATUS, 8'hd0);
				{m_mode2, m_rnf, m_wf, m_lost} = 4'b0000;
				break;
			end
			a = sector_addr(cur_sec) + 20'(idx);
			if (count == skip_idx) begin
				while (drq)
					next_cycle();
				m_lost = 1'b1;
			end else if (c[5]) begin
				d = 8'($urandom);
				wb_write(fdc_pkg::REG_DATA, d);
				img_model[a] = d;
			end else begin
				wb_read(fdc_pkg::REG_DATA, d);
				check_byte("data register", d, image_byte(a));
			end
			count++;
			idx++;
			if (idx == len) begin
				idx = 0;
				cur_sec++;
			end
		end
		if (count != due) begin
			$display("sector command %h moved %0d bytes instead of %0d", c, count, due);
			abort_run();
		end
		while (!intrq)
			next_cycle();
		wb_read(fdc_pkg::REG_CMD_STATUS, d);
		check_status(d, exp_status());
		wb_read(fdc_pkg::REG_SECTOR, d);
		check_byte("sector register", d, m_sector);
	endtask

	// ====================
	// main sequence
	initial begin
		int spt;
		void'($urandom(32'h8b62));
		rst       = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = 2'd0;
		wb_dat_w  = 8'h00;
		ready     = 1'b1;
		wp        = 1'b0;
		side      = 1'b0;
		size_code = 3'd0;
		{m_head, m_track, m_sector} = '0;
		{m_dir_in, m_loaded, m_mode2, m_rnf, m_wf, m_lost} = 6'b100000;
		repeat (16) @(posedge clk_sys);
		#2;
		rst = 1'b0;

		for (int i = 0; i < N_TYPE1; i++)
			type1_cmd({4'($urandom_range(7, 0)), 4'($urandom)}, 8'($urandom_range(60, 0)));

		for (int i = 0; i < N_RW; i++) begin
			size_code = 3'($urandom_range(4, 0));
			side      = 1'($urandom_range(1, 0));
			spt       = spt_of(size_code);
			type1_cmd(8'h10, 8'($urandom_range(70, 0)));
			set_sector(8'($urandom_range(spt, 1)));
			sector_cmd(8'h80, -1, -1);
			wp = $urandom_range(2, 0) == 0;
			sector_cmd(8'ha0, -1, -1);
			wp = 1'b0;
			sector_cmd(8'h80, -1, -1);  // read back
			if (i % 2 == 0)
				set_sector($urandom_range(1, 0) ? 8'd0 : 8'(spt + 1 + $urandom_range(2, 0)));
			else
				ready = 1'b0;
			sector_cmd(8'h80, -1, -1);
			ready = 1'b1;
			set_sector(8'($urandom_range(spt, 1)));
			sector_cmd(8'h90, -1, -1);  // multi sector
		end

		for (int i = 0; i < N_FORCE; i++) begin
			size_code = 3'($urandom_range(4, 0));
			type1_cmd(8'h10, 8'($urandom_range(70, 0)));
			set_sector(8'($urandom_range(spt_of(size_code), 1)));
			sector_cmd(8'h80, -1, $urandom_range(5, 0));
		end

		// 128 byte sectors with one byte left to the watchdog
		size_code = 3'd0;
		for (int i = 0; i < N_LOST; i++) begin
			type1_cmd(8'h10, 8'($urandom_range(70, 0)));
			set_sector(8'($urandom_range(26, 1)));
			sector_cmd(8'h80, $urandom_range(127, 0), -1);
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== sim.f ====
hw/fdc_pkg.sv
hw/fdc_geometry.sv
hw/fdc_host_regs.sv
hw/fdc_cmd_seq.sv
hw/fdc_img_master.sv
hw/fdc_top.sv
tests/fdc_image_mem.sv
tests/fdc_tb.sv
